// ==== all.f ====
+incdir+verilog
verilog/frogger_pkg.sv
verilog/lilypad.sv
verilog/lilypad_row.sv
verilog/car.sv
verilog/car_row.sv
verilog/lane_judge.sv
verilog/frog_lane_top.sv
test/frog_lane_chk.sv
test/frog_lane_tb.sv

// ==== test/frog_lane_tb.sv ====
// Directed testbench for frog_lane_top, checks motion, overlap and outcome against a model
`timescale 1ns/10ps
`default_nettype none

`include "frogger_config.svh"

module frog_lane_tb
	import frogger_pkg::*;
();

	localparam int MAX_CYCLES = 2000;
	localparam int WATER_Y    = 100;
	localparam int ROAD_Y     = 200;

	logic          frame_clk;
	logic          arst_n;
	logic          win;
	logic          lose;
	row_cfg_t      water_cfg;
	row_cfg_t      road_cfg;
	frog_pos_t     frog;
	row_xs_t       pad_x;
	row_xs_t       car_x;
	lane_outcome_t outcome;

	// Model of positions, dividers and the registered outcome
	int          m_pad[4];
	int          m_car[4];
	int          m_pad_rem;
	int          m_car_rem;
	logic        exp_lost;
	logic        exp_ride;
	logic        exp_dir;
	// Inputs the DUT sees at the next edge
	logic        cur_freeze;
	frog_pos_t   cur_frog;
	logic [31:0] seed   = 32'ha0c0;
	int          cycles = 0;

	frog_lane_top UUT (
		.frame_clk (frame_clk),
		.arst_n    (arst_n),
		.water_cfg (water_cfg),
		.road_cfg  (road_cfg),
		.frog      (frog),
		.win       (win),
		.lose      (lose),
		.pad_x     (pad_x),
		.car_x     (car_x),
		.outcome   (outcome)
	);

	// ----------------------------------------
	// Clock and watchdog
	// ----------------------------------------

	initial
	begin
		frame_clk = 1'b0;
		forever #20 frame_clk = ~frame_clk;
	end

	always @(posedge frame_clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Run stopped after %0d cycles, a test never finished", cycles);
			$display("Something failed");
			$fatal(1);
		end
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic row_cfg_t make_cfg(int count, int gap, int speed, logic dir, int y);
		row_cfg_t c;
		c.spare = 1'b0;
		c.count = 3'(count);
		c.gap   = 8'(gap);
		c.speed = `SPEED_BITS'(speed);
		c.dir   = dir;
		c.row_y = coord_t'(y);
		return c;
	endfunction

	function automatic frog_pos_t frog_at(int x, int y);
		frog_pos_t f;
		f.x = coord_t'(x);
		f.y = coord_t'(y);
		return f;
	endfunction

	// Frog x inside a sprite of width w starting at sx, across the wrap
	function automatic logic covers(int fx, int sx, int w);
		return ((fx + `SCREEN_W - sx) % `SCREEN_W) < w;
	endfunction

	function automatic int move(int x, logic dir);
		return dir ? (x + 1) % `SCREEN_W : (x + `SCREEN_W - 1) % `SCREEN_W;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("mismatch in %s: expected %0d, actual %0d", name, expected, actual);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	// One clock edge in the model, judge first then move
	task automatic model_edge();
		logic on_w;
		logic on_r;
		logic w_ovl;
		logic r_ovl;
		logic w_step;
		logic r_step;
		on_w  = (cur_frog.y == water_cfg.row_y);
		on_r  = (cur_frog.y == road_cfg.row_y);
		w_ovl = 1'b0;
		r_ovl = 1'b0;
		for (int i = 0; i < 4; i++)
		begin
			if (i < water_cfg.count && covers(cur_frog.x, m_pad[i], `PAD_W))
				w_ovl = 1'b1;
			if (i < road_cfg.count && covers(cur_frog.x, m_car[i], `CAR_W))
				r_ovl = 1'b1;
		end
		exp_dir  = water_cfg.dir;
		exp_lost = 1'b0;
		exp_ride = 1'b0;
		if (!cur_freeze)
		begin
			w_step    = (m_pad_rem == water_cfg.speed - 1);
			r_step    = (m_car_rem == road_cfg.speed - 1);
			exp_lost  = (on_w && !w_ovl) || (on_r && r_ovl);
			exp_ride  = on_w && w_ovl && w_step;
			m_pad_rem = w_step ? 0 : m_pad_rem + 1;
			m_car_rem = r_step ? 0 : m_car_rem + 1;
			for (int i = 0; i < 4; i++)
			begin
				if (w_step)
					m_pad[i] = move(m_pad[i], water_cfg.dir);
				if (r_step)
					m_car[i] = move(m_car[i], road_cfg.dir);
			end
		end
	endtask

	task automatic check_frame(input string name);
		for (int i = 0; i < 4; i++)
		begin
			check_value({name, " pad x"}, m_pad[i], pad_x[i]);
			check_value({name, " car x"}, m_car[i], car_x[i]);
		end
		check_value({name, " lost"}, exp_lost, outcome.lost);
		check_value({name, " ride"}, exp_ride, outcome.ride);
		check_value({name, " ride_dir"}, exp_dir, outcome.ride_dir);
	endtask

	// Reset with new row setups, frog parked off both rows
	task automatic apply_reset(input row_cfg_t wc, input row_cfg_t rc);
		@(posedge frame_clk);
		arst_n    <= 1'b0;
		water_cfg <= wc;
		road_cfg  <= rc;
		win       <= 1'b0;
		lose      <= 1'b0;
		frog      <= frog_at(0, 0);
		repeat (3) @(posedge frame_clk);
		arst_n <= 1'b1;
		for (int i = 0; i < 4; i++)
		begin
			m_pad[i] = (i * (wc.gap + `PAD_W)) % `SCREEN_W;
			m_car[i] = (i * (rc.gap + `CAR_W)) % `SCREEN_W;
		end
		m_pad_rem  = 0;
		m_car_rem  = 0;
		exp_lost   = 1'b0;
		exp_ride   = 1'b0;
		exp_dir    = 1'b0;
		cur_freeze = 1'b0;
		cur_frog   = frog_at(0, 0);
		@(negedge frame_clk);
	endtask

	// Drive one frame and compare everything after the edge
	task automatic advance(input logic w, input logic l, input frog_pos_t f, input string name);
		@(posedge frame_clk);
		model_edge();
		win        <= w;
		lose       <= l;
		frog       <= f;
		cur_freeze = w || l;
		cur_frog   = f;
		@(negedge frame_clk);
		check_frame(name);
	endtask

	// ----------------------------------------
	// Directed tests
	// ----------------------------------------

	task automatic test_reset_layout();
		apply_reset(make_cfg(4, 200, 5, 1'b1, WATER_Y), make_cfg(4, 255, 7, 1'b0, ROAD_Y));
		for (int i = 0; i < 4; i++)
		begin
			check_value("test_reset_layout pad x", (i * 240) % 640, pad_x[i]);
			check_value("test_reset_layout car x", (i * 295) % 640, car_x[i]);
		end
		check_value("test_reset_layout lost", 0, outcome.lost);
		check_value("test_reset_layout ride", 0, outcome.ride);
	endtask

	// Long enough for water to pass 639 and road to pass 0
	task automatic test_motion_wrap();
		apply_reset(make_cfg(4, 120, 3, 1'b1, WATER_Y), make_cfg(4, 80, 2, 1'b0, ROAD_Y));
		repeat (700)
			advance(1'b0, 1'b0, frog_at(0, 0), "test_motion_wrap");
	endtask

	task automatic test_pad_overlap();
		int counts[3] = '{0, 2, 4};
		for (int k = 0; k < 3; k++)
		begin
			apply_reset(make_cfg(counts[k], 60, 2, 1'b0, WATER_Y), make_cfg(0, 0, 1, 1'b1, ROAD_Y));
			repeat (30)
				advance(1'b0, 1'b0, frog_at(lcg_next() % 640, WATER_Y), "test_pad_overlap");
		end
	endtask

	// Frog is carried along with the pad it stands on
	task automatic test_ride();
		int fx;
		int rides;
		for (int d = 0; d < 2; d++)
		begin
			apply_reset(make_cfg(4, 100, 4, 1'(d), WATER_Y), make_cfg(2, 200, 3, 1'b1, ROAD_Y));
			fx    = 20;
			rides = 0;
			repeat (80)
			begin
				advance(1'b0, 1'b0, frog_at(fx, WATER_Y), "test_ride");
				if (outcome.ride)
				begin
					fx = move(fx, 1'(d));
					rides++;
				end
			end
			// Speed 4 over 80 frames
			check_value("test_ride pulses", 20, rides);
		end
	endtask

	task automatic test_road_hit();
		apply_reset(make_cfg(4, 60, 3, 1'b1, WATER_Y), make_cfg(3, 120, 1, 1'b1, ROAD_Y));
		repeat (50)
			advance(1'b0, 1'b0, frog_at(lcg_next() % 640, ROAD_Y), "test_road_hit");
		advance(1'b0, 1'b0, frog_at(320, 300), "test_road_hit");
		repeat (20)
		begin
			advance(1'b0, 1'b0, frog_at(lcg_next() % 640, 300), "test_road_hit");
			check_value("test_road_hit off lanes", 0, outcome.lost);
		end
	endtask

	task automatic test_freeze();
		int snap_pad;
		int snap_car;
		apply_reset(make_cfg(4, 60, 2, 1'b1, WATER_Y), make_cfg(4, 100, 3, 1'b0, ROAD_Y));
		repeat (20)
			advance(1'b0, 1'b0, frog_at(50, WATER_Y), "test_freeze");
		// Win first, then lose
		for (int k = 0; k < 2; k++)
		begin
			advance(k == 0, k == 1, frog_at(50, WATER_Y), "test_freeze");
			snap_pad = m_pad[0];
			snap_car = m_car[0];
			repeat (50)
				advance(k == 0, k == 1, frog_at(50, WATER_Y), "test_freeze");
			check_value("test_freeze pad hold", snap_pad, pad_x[0]);
			check_value("test_freeze car hold", snap_car, car_x[0]);
			repeat (15)
				advance(1'b0, 1'b0, frog_at(50, WATER_Y), "test_freeze");
		end
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------

	initial
	begin
		arst_n     = 1'b0;
		win        = 1'b0;
		lose       = 1'b0;
		water_cfg  = '0;
		road_cfg   = '0;
		frog       = '0;
		cur_freeze = 1'b0;
		cur_frog   = '0;
		test_reset_layout();
		test_motion_wrap();
		test_pad_overlap();
		test_ride();
		test_road_hit();
		test_freeze();
		@(negedge frame_clk);
		if (UUT.u_chk.failures != 0)
		begin
			$display("%0d output assertions failed", UUT.u_chk.failures);
			$display("Something failed");
			$fatal(1);
		end
		else
		begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== test/frog_lane_chk.sv ====
// Output assertions for the lane pair, bound into frog_lane_top for every testbench run
`timescale 1ns/10ps
`default_nettype none

`include "frogger_config.svh"

module frog_lane_chk
	import frogger_pkg::*;
(
	input wire logic          frame_clk,
	input wire logic          arst_n,
	input wire logic          win,
	input wire logic          lose,
	input wire row_xs_t       pad_x,
	input wire row_xs_t       car_x,
	input wire lane_outcome_t outcome
);

	// Count of failed assertions, read by the testbench at the end
	int unsigned failures = 0;

	// Every slot of a row lies on the screen
	function automatic logic on_screen(row_xs_t xs);
		logic ok;
		ok = 1'b1;
		for (int i = 0; i < `ROW_SLOTS; i++)
			ok = ok && (xs[i] < coord_t'(`SCREEN_W));
		return ok;
	endfunction

	// Carried and lost exclude each other
	a_excl: assert property (@(posedge frame_clk) disable iff (!arst_n)
		!(outcome.ride && outcome.lost))
	else
	begin
		failures++;
		$error("ride and lost are high in the same frame");
	end

	// First frame out of reset shows a clear outcome
	a_reset: assert property (@(posedge frame_clk) $rose(arst_n) |-> (outcome == '0))
	else
	begin
		failures++;
		$error("outcome not clear after reset release");
	end

	a_range: assert property (@(posedge frame_clk) disable iff (!arst_n)
		on_screen(pad_x) && on_screen(car_x))
	else
	begin
		failures++;
		$error("sprite position off the screen");
	end

	// Frozen frame, nothing moves on the next edge
	a_hold: assert property (@(posedge frame_clk) disable iff (!arst_n)
		(win || lose) |=> ($stable(pad_x) && $stable(car_x)))
	else
	begin
		failures++;
		$error("sprite moved while win or lose was high");
	end

endmodule

bind frog_lane_top frog_lane_chk u_chk (
	.frame_clk (frame_clk),
	.arst_n    (arst_n),
	.win       (win),
	.lose      (lose),
	.pad_x     (pad_x),
	.car_x     (car_x),
	.outcome   (outcome)
);

`default_nettype wire

// ==== verilog/frog_lane_top.sv ====
// Top level of the lane pair, wires the water and road rows into the judge
`timescale 1ns/10ps
`default_nettype none

module frog_lane_top
	import frogger_pkg::*;
(
	input  wire logic      frame_clk,
	input  wire logic      arst_n,
	input  wire row_cfg_t  water_cfg,
	input  wire row_cfg_t  road_cfg,
	input  wire frog_pos_t frog,
	input  wire logic      win,
	input  wire logic      lose,
	output row_xs_t        pad_x,
	output row_xs_t        car_x,
	output lane_outcome_t  outcome
);

	// Per-frame results of both rows
	row_status_t water_status;
	row_status_t road_status;

	// ----------------------------------------
	// Rows
	// ----------------------------------------

	// Water row, lilypads
	lilypad_row u_water (
		.frame_clk (frame_clk),
		.arst_n    (arst_n),
		.cfg       (water_cfg),
		.frog      (frog),
		.win       (win),
		.lose      (lose),
		.pad_x     (pad_x),
		.status    (water_status)
	);

	// Road row, cars
	car_row u_road (
		.frame_clk (frame_clk),
		.arst_n    (arst_n),
		.cfg       (road_cfg),
		.frog      (frog),
		.win       (win),
		.lose      (lose),
		.car_x     (car_x),
		.status    (road_status)
	);

	// Judge sees each row's y straight from its configuration
	lane_judge u_judge (
		.frame_clk (frame_clk),
		.arst_n    (arst_n),
		.water_y   (water_cfg.row_y),
		.road_y    (road_cfg.row_y),
		.frog      (frog),
		.water     (water_status),
		.road      (road_status),
		.win       (win),
		.lose      (lose),
		.outcome   (outcome)
	);

endmodule

`default_nettype wire

// ==== verilog/lane_judge.sv ====
// Frame outcome register, decides from both row results whether the frog is lost or carried
`timescale 1ns/10ps
`default_nettype none

module lane_judge
	import frogger_pkg::*;
(
	input  wire logic        frame_clk,
	input  wire logic        arst_n,
	input  wire coord_t      water_y,
	input  wire coord_t      road_y,
	input  wire frog_pos_t   frog,
	input  wire row_status_t water,
	input  wire row_status_t road,
	input  wire logic        win,
	input  wire logic        lose,
	output lane_outcome_t    outcome
);

	logic on_water;
	logic on_road;
	logic freeze;
	logic lost_next;
	logic ride_next;

	// ----------------------------------------
	// Lane decode
	// ----------------------------------------

	// Frog lane from its y, neither row means safe ground
	assign on_water = (frog.y == water_y);
	assign on_road  = (frog.y == road_y);
	assign freeze   = win | lose;

	// Drowned off every pad, or run over
	assign lost_next = !freeze &&
		((on_water && !water.overlap) || (on_road && road.overlap));

	// Carried when the pad under the frog moves this frame
	// a lost frog is never carried, even with both rows on one y
	assign ride_next = !freeze && !lost_next &&
		on_water && water.overlap && water.step;

	// ----------------------------------------
	// Outcome register
	// ----------------------------------------

	// Pulses last one frame, direction follows the water row
	always_ff @(posedge frame_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			outcome <= '0;
		end
		else
		begin
			outcome.lost     <= lost_next;
			outcome.ride     <= ride_next;
			outcome.ride_dir <= water.dir;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/car_row.sv ====
// Road row of four cars, merges their hits on the frog under the active car count
`timescale 1ns/10ps
`default_nettype none

`include "frogger_config.svh"

module car_row
	import frogger_pkg::*;
(
	input  wire logic      frame_clk,
	input  wire logic      arst_n,
	input  wire row_cfg_t  cfg,
	input  wire frog_pos_t frog,
	input  wire logic      win,
	input  wire logic      lose,
	output row_xs_t        car_x,
	output row_status_t    status
);

	coord_t                span;
	logic [`ROW_SLOTS-1:0] hit;
	logic [`ROW_SLOTS-1:0] active;

	// Distance between left edges of neighbouring cars
	assign span = coord_t'(cfg.gap) + coord_t'(`CAR_W);

	// ----------------------------------------
	// Car slots
	// ----------------------------------------

	for (genvar i = 0; i < `ROW_SLOTS; i++)
	begin : g_car
		coord_t raw_x;
		coord_t start_x;

		// Start position i * span folded back onto the screen
		assign raw_x   = coord_t'(i) * span;
		assign start_x = (raw_x >= coord_t'(`SCREEN_W)) ? raw_x - coord_t'(`SCREEN_W) : raw_x;
		assign active[i] = (cfg.count > 3'(i));

		car u_car (
			.frame_clk (frame_clk),
			.arst_n    (arst_n),
			.start_x   (start_x),
			.cfg       (cfg),
			.frog      (frog),
			.win       (win),
			.lose      (lose),
			.x         (car_x[i]),
			.hit       (hit[i])
		);
	end

	// Any enabled car on the frog kills it
	assign status.overlap = |(hit & active);
	// Nothing rides a car, so no step is reported
	assign status.step = 1'b0;
	assign status.dir  = cfg.dir;

endmodule

`default_nettype wire

// ==== verilog/car.sv ====
// One car sprite with frame divider and wrapping x, instantiated per slot by car_row
`timescale 1ns/10ps
`default_nettype none

`include "frogger_config.svh"

module car
	import frogger_pkg::*;
(
	input  wire logic      frame_clk,
	input  wire logic      arst_n,
	input  wire coord_t    start_x,
	input  wire row_cfg_t  cfg,
	input  wire frog_pos_t frog,
	input  wire logic      win,
	input  wire logic      lose,
	output coord_t         x,
	output logic           hit
);

	logic [`SPEED_BITS-1:0] remainder;
	logic                   wrap;
	coord_t                 x_next;
	coord_t                 fwd;

	// ----------------------------------------
	// Motion
	// ----------------------------------------

	assign wrap = (remainder == cfg.speed - `SPEED_BITS'(1));

	// One pixel left or right, wraps around the screen
	always_comb
	begin
		if (cfg.dir)
			x_next = (x == coord_t'(`SCREEN_W - 1)) ? '0 : x + coord_t'(1);
		else
			x_next = (x == '0) ? coord_t'(`SCREEN_W - 1) : x - coord_t'(1);
	end

	// Divider counts frames, car moves on its last frame, holds while frozen
	always_ff @(posedge frame_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			x         <= start_x;
			remainder <= '0;
		end
		else if (!(win || lose))
		begin
			remainder <= wrap ? '0 : remainder + `SPEED_BITS'(1);
			if (wrap)
				x <= x_next;
		end
	end

	// ----------------------------------------
	// Collision
	// ----------------------------------------

	// Frog x measured from the car's left edge across the wrap
	assign fwd = (frog.x >= x) ? frog.x - x : frog.x + coord_t'(`SCREEN_W) - x;
	assign hit = (frog.y == cfg.row_y) && (fwd < coord_t'(`CAR_W));

endmodule

`default_nettype wire

// ==== verilog/lilypad_row.sv ====
// Water row of four lilypads, merges their frog overlap under the active pad count
`timescale 1ns/10ps
`default_nettype none

`include "frogger_config.svh"

module lilypad_row
	import frogger_pkg::*;
(
	input  wire logic      frame_clk,
	input  wire logic      arst_n,
	input  wire row_cfg_t  cfg,
	input  wire frog_pos_t frog,
	input  wire logic      win,
	input  wire logic      lose,
	output row_xs_t        pad_x,
	output row_status_t    status
);

	coord_t                              span;
	logic [`ROW_SLOTS-1:0]               touch;
	logic [`ROW_SLOTS-1:0]               active;
	logic [`ROW_SLOTS-1:0][`SPEED_BITS-1:0] remainder;

	// Pitch from one pad to the next
	assign span = coord_t'(cfg.gap) + coord_t'(`PAD_W);

	// ----------------------------------------
	// Pad slots
	// ----------------------------------------

	for (genvar i = 0; i < `ROW_SLOTS; i++)
	begin : g_pad
		coord_t raw_x;
		coord_t start_x;

		// Slot offset, never reaches two screen widths
		assign raw_x   = coord_t'(i) * span;
		assign start_x = (raw_x >= coord_t'(`SCREEN_W)) ? raw_x - coord_t'(`SCREEN_W) : raw_x;

		// Disabled slots still move but cannot hold the frog
		assign active[i] = (cfg.count > 3'(i));

		lilypad u_pad (
			.frame_clk (frame_clk),
			.arst_n    (arst_n),
			.start_x   (start_x),
			.cfg       (cfg),
			.frog      (frog),
			.win       (win),
			.lose      (lose),
			.x         (pad_x[i]),
			.remainder (remainder[i]),
			.touch     (touch[i])
		);
	end

	// Frog stands on any enabled pad
	assign status.overlap = |(touch & active);
	// Slot 0 wraps its divider this frame, all slots share the speed
	assign status.step = (remainder[0] == cfg.speed - `SPEED_BITS'(1)) && !(win || lose);
	assign status.dir  = cfg.dir;

endmodule

`default_nettype wire

// ==== verilog/lilypad.sv ====
// One lilypad sprite with frame divider and wrapping x, instantiated per slot by lilypad_row
`timescale 1ns/10ps
`default_nettype none

`include "frogger_config.svh"

module lilypad
	import frogger_pkg::*;
(
	input  wire logic                   frame_clk,
	input  wire logic                   arst_n,
	input  wire coord_t                 start_x,
	input  wire row_cfg_t               cfg,
	input  wire frog_pos_t              frog,
	input  wire logic                   win,
	input  wire logic                   lose,
	output coord_t                      x,
	output logic [`SPEED_BITS-1:0]      remainder,
	output logic                        touch
);

	logic   freeze;
	logic   wrap;
	coord_t x_next;
	coord_t fwd;

	// ----------------------------------------
	// Frame divider
	// ----------------------------------------

	// Game over or won, everything stands still
	assign freeze = win | lose;

	// Last frame of the divider period
	assign wrap = (remainder == cfg.speed - `SPEED_BITS'(1));

	// Next pixel in the row direction, wraps at both screen edges
	always_comb
	begin
		if (cfg.dir)
			x_next = (x == coord_t'(`SCREEN_W - 1)) ? '0 : x + coord_t'(1);
		else
			x_next = (x == '0) ? coord_t'(`SCREEN_W - 1) : x - coord_t'(1);
	end

	// Counter and position, start slot loaded on reset
	always_ff @(posedge frame_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			x         <= start_x;
			remainder <= '0;
		end
		else if (!freeze)
		begin
			if (wrap)
			begin
				remainder <= '0;
				x         <= x_next;
			end
			else
				remainder <= remainder + `SPEED_BITS'(1);
		end
	end

	// ----------------------------------------
	// Overlap with the frog
	// ----------------------------------------

	// Distance from pad left edge to frog, modulo the screen
	assign fwd = (frog.x >= x) ? frog.x - x : frog.x + coord_t'(`SCREEN_W) - x;

	// Frog on this row and inside the pad span
	assign touch = (frog.y == cfg.row_y) && (fwd < coord_t'(`PAD_W));

endmodule

`default_nettype wire

// ==== verilog/frogger_pkg.sv ====
// Shared coordinate, row and outcome types for the lane pair RTL and its testbench
`default_nettype none

`include "frogger_config.svh"

package frogger_pkg;

	// ----------------------------------------
	// Coordinates
	// ----------------------------------------

	// One screen coordinate, x or y
	typedef logic [`COORD_BITS-1:0] coord_t;

	// Frog position as sampled by the judge
	typedef struct packed {
		coord_t x;
		coord_t y;
	} frog_pos_t;

	// X position of every slot in a row, slot 0 in the low bits
	typedef coord_t [`ROW_SLOTS-1:0] row_xs_t;

	// ----------------------------------------
	// Row configuration and status
	// ----------------------------------------

	// Static row setup, only changed while in reset
	typedef struct packed {
		logic                   spare;
		logic [2:0]             count;  // active sprites 0..4
		logic [7:0]             gap;    // pixels between sprites
		logic [`SPEED_BITS-1:0] speed;  // frames per pixel step
		logic                   dir;    // 1 moves right
		coord_t                 row_y;
	} row_cfg_t;

	// Combinational per-frame result of one row
	typedef struct packed {
		logic overlap;
		logic step;
		logic dir;
	} row_status_t;

	// Registered frame outcome of the judge
	typedef struct packed {
		logic lost;
		logic ride;
		logic ride_dir;
	} lane_outcome_t;

endpackage

`default_nettype wire

// ==== verilog/frogger_config.svh ====
// Build constants for the frog lane pair, included by the package and by the RTL that needs them
`ifndef FROGGER_CONFIG_SVH
`define FROGGER_CONFIG_SVH

// ----------------------------------------
// Screen geometry
// ----------------------------------------

// Horizontal positions per line, x runs 0..639
`define SCREEN_W 640

// Width of every coordinate, covers twice the screen for wrap math
`define COORD_BITS 11

// ----------------------------------------
// Row contents
// ----------------------------------------

// Sprite slots per row, a row may enable fewer
`define ROW_SLOTS 4

// Lilypad sprite width in pixels
`define PAD_W 40

// Car sprite width in pixels
`define CAR_W 40

// Frame divider width, speed is 1..63 frames per pixel
`define SPEED_BITS 6

`endif
